// File: design/sccb_pkg.sv
`default_nettype none

package sccb_pkg;

	// ----------------------------------------
	// sensor and table geometry
	// ----------------------------------------
	localparam logic [7:0] SLAVE_ADDR = 8'h60;	// ov2640 write address
	localparam int TABLE_DEPTH = 16;
	localparam int TABLE_INDEX_W = 4;

	// ----------------------------------------
	// bus pacing and limits
	// ----------------------------------------
	localparam int SCL_QUARTER = 4;	// clocks per quarter scl period
	localparam int DELAY_TICK = 64;	// clocks per delay tick
	localparam int MAX_RETRIES = 3;

	// raw kind codes as stored in the table
	localparam logic [1:0] ENTRY_WRITE = 2'b00;
	localparam logic [1:0] ENTRY_DELAY = 2'b01;
	localparam logic [1:0] ENTRY_END = 2'b11;

	// one table word, 18 bits
	typedef struct packed {
		logic [1:0] kind;
		logic [7:0] reg_addr;
		logic [7:0] data;	// tick count on a delay entry
	} init_entry_t;

	typedef enum logic [1:0] {
		CMD_WRITE = 2'd0,
		CMD_DELAY = 2'd1,
		CMD_END = 2'd2
	} cmd_kind_t;

	// decoded command handed to the sequencer
	typedef struct packed {
		cmd_kind_t kind;
		logic [7:0] reg_addr;
		logic [7:0] data;
	} sccb_cmd_t;

endpackage

`default_nettype wire

// File: design/init_rom.sv
`timescale 1ns/100ps
`default_nettype none

module init_rom (
	input wire [sccb_pkg::TABLE_INDEX_W-1:0] index,
	output sccb_pkg::sccb_cmd_t cmd
);

	sccb_pkg::init_entry_t entry;

	// short power-up list, register bank select first
	function automatic sccb_pkg::init_entry_t table_entry(
		input logic [sccb_pkg::TABLE_INDEX_W-1:0] idx
	);
		sccb_pkg::init_entry_t e;
		case (int'(idx))
			0: e = '{sccb_pkg::ENTRY_WRITE, 8'hff, 8'h01};
			1: e = '{sccb_pkg::ENTRY_WRITE, 8'h12, 8'h80};	// soft reset
			2: e = '{sccb_pkg::ENTRY_DELAY, 8'h00, 8'h05};	// settle after reset
			3: e = '{sccb_pkg::ENTRY_WRITE, 8'hff, 8'h00};
			4: e = '{sccb_pkg::ENTRY_WRITE, 8'h2c, 8'hff};
			5: e = '{sccb_pkg::ENTRY_WRITE, 8'h2e, 8'hdf};
			6: e = '{sccb_pkg::ENTRY_WRITE, 8'hff, 8'h01};
			7: e = '{sccb_pkg::ENTRY_WRITE, 8'h3c, 8'h32};
			8: e = '{sccb_pkg::ENTRY_WRITE, 8'h11, 8'h00};
			9: e = '{sccb_pkg::ENTRY_WRITE, 8'h09, 8'h02};
			10: e = '{sccb_pkg::ENTRY_END, 8'h00, 8'h00};
			// unused slots stop the walk
			default: e = '{sccb_pkg::ENTRY_END, 8'h00, 8'h00};
		endcase
		return e;
	endfunction

	// ----------------------------------------
	// decode raw kind into command kind
	// ----------------------------------------
	always_comb
	begin
		entry = table_entry(index);
		cmd.reg_addr = entry.reg_addr;
		cmd.data = entry.data;
		case (entry.kind)
			sccb_pkg::ENTRY_WRITE: cmd.kind = sccb_pkg::CMD_WRITE;
			sccb_pkg::ENTRY_DELAY: cmd.kind = sccb_pkg::CMD_DELAY;
			sccb_pkg::ENTRY_END: cmd.kind = sccb_pkg::CMD_END;
			default: cmd.kind = sccb_pkg::CMD_END;	// unknown code ends the list
		endcase
	end

endmodule

`default_nettype wire

// File: design/init_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module init_sequencer (
	input wire clk,
	input wire reset_n,
	output logic [sccb_pkg::TABLE_INDEX_W-1:0] index,
	input wire sccb_pkg::sccb_cmd_t cmd,
	output logic cmd_valid,
	output logic [7:0] cmd_reg,
	output logic [7:0] cmd_data,
	input wire cmd_ready,
	input wire done,
	input wire nack,
	output logic ready,
	output logic error
);

	localparam int IDX_W = sccb_pkg::TABLE_INDEX_W;
	localparam int DELAY_W = $clog2(256 * sccb_pkg::DELAY_TICK);
	localparam int RETRY_W = $clog2(sccb_pkg::MAX_RETRIES + 1);

	typedef enum logic [2:0] {
		S_FETCH,
		S_ISSUE,
		S_WAIT,
		S_DELAY,
		S_FINISH
	} seq_state_t;

	seq_state_t state;
	logic [DELAY_W-1:0] delay_cnt;
	logic [RETRY_W-1:0] retry_cnt;
	logic [IDX_W-1:0] next_index;
	logic retries_spent;

	// hold on the last slot, it always decodes to end
	assign next_index = (index == IDX_W'(sccb_pkg::TABLE_DEPTH - 1)) ? index : index + 1'b1;
	assign retries_spent = (retry_cnt == RETRY_W'(sccb_pkg::MAX_RETRIES));

	// ----------------------------------------
	// table walk FSM
	// ----------------------------------------
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			state <= S_FETCH;
			index <= '0;
			cmd_valid <= 1'b0;
			delay_cnt <= '0;
			retry_cnt <= '0;
			ready <= 1'b0;
			error <= 1'b0;
		end
		else
		begin
			case (state)
				S_FETCH:
				begin
					case (cmd.kind)
						sccb_pkg::CMD_WRITE:
						begin
							cmd_valid <= 1'b1;
							state <= S_ISSUE;
						end
						sccb_pkg::CMD_DELAY:
						begin
							delay_cnt <= DELAY_W'(cmd.data) * DELAY_W'(sccb_pkg::DELAY_TICK);
							state <= S_DELAY;
						end
						default:
						begin
							ready <= 1'b1;
							state <= S_FINISH;
						end
					endcase
				end
				S_ISSUE:
				begin
					if (cmd_ready)
					begin
						cmd_valid <= 1'b0;	// master has taken it
						state <= S_WAIT;
					end
				end
				S_WAIT:
				begin
					if (done)
					begin
						if (!nack)
						begin
							retry_cnt <= '0;
							index <= next_index;
							state <= S_FETCH;
						end
						else if (retries_spent)
						begin
							error <= 1'b1;	// give up, bus stays idle
							state <= S_FINISH;
						end
						else
						begin
							retry_cnt <= retry_cnt + 1'b1;
							cmd_valid <= 1'b1;	// same bytes again
							state <= S_ISSUE;
						end
					end
				end
				S_DELAY:
				begin
					if (delay_cnt <= DELAY_W'(1))
					begin
						retry_cnt <= '0;
						index <= next_index;
						state <= S_FETCH;
					end
					else
						delay_cnt <= delay_cnt - 1'b1;
				end
				S_FINISH:
				begin
					state <= S_FINISH;	// parked until reset
				end
				default: state <= S_FETCH;
			endcase
		end
	end

	// write payload, captured when a write is fetched
	always_ff @(posedge clk)
	begin
		if (state == S_FETCH && cmd.kind == sccb_pkg::CMD_WRITE)
		begin
			cmd_reg <= cmd.reg_addr;
			cmd_data <= cmd.data;
		end
	end

endmodule

`default_nettype wire

// File: design/sccb_master.sv
`timescale 1ns/100ps
`default_nettype none

module sccb_master (
	input wire clk,
	input wire reset_n,
	input wire cmd_valid,
	input wire [7:0] cmd_reg,
	input wire [7:0] cmd_data,
	output logic cmd_ready,
	output logic done,
	output logic nack,
	output logic scl,
	output logic sda_out,
	output logic sda_oe,
	input wire sda_in
);

	localparam int TICK_W = (sccb_pkg::SCL_QUARTER > 1) ? $clog2(sccb_pkg::SCL_QUARTER) : 1;

	typedef enum logic [1:0] {
		M_IDLE,
		M_START,
		M_BITS,
		M_STOP
	} bus_state_t;

	bus_state_t state;
	logic [TICK_W-1:0] tick_cnt;
	logic [1:0] quarter;	// 0,1 scl low, 2,3 scl high
	logic [3:0] bit_cnt;	// 8 is the ack slot
	logic [1:0] byte_cnt;
	logic [23:0] shift;
	logic nack_acc;
	logic quarter_end;
	logic slot_end;
	logic ack_slot;
	logic scl_rise;
	logic scl_d;
	logic sda_out_d;
	logic sda_oe_d;

	assign quarter_end = (tick_cnt == TICK_W'(sccb_pkg::SCL_QUARTER - 1));
	assign slot_end = quarter_end && (quarter == 2'd3);
	assign ack_slot = (bit_cnt == 4'd8);
	assign scl_rise = scl_d && !scl;
	assign cmd_ready = (state == M_IDLE);

	// ----------------------------------------
	// pacing and bit sequencing
	// ----------------------------------------
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			state <= M_IDLE;
			tick_cnt <= '0;
			quarter <= 2'd0;
			bit_cnt <= 4'd0;
			byte_cnt <= 2'd0;
			nack_acc <= 1'b0;
			done <= 1'b0;
			nack <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (state != M_IDLE)
			begin
				tick_cnt <= quarter_end ? '0 : tick_cnt + 1'b1;
				if (quarter_end)
					quarter <= quarter + 1'b1;
			end
			// ack read as scl goes high
			if (state == M_BITS && ack_slot && scl_rise)
				nack_acc <= nack_acc | sda_in;
			case (state)
				M_IDLE:
				begin
					if (cmd_valid)
					begin
						state <= M_START;
						tick_cnt <= '0;
						quarter <= 2'd0;
						bit_cnt <= 4'd0;
						byte_cnt <= 2'd0;
						nack_acc <= 1'b0;
					end
				end
				M_START:
				begin
					if (slot_end)
						state <= M_BITS;
				end
				M_BITS:
				begin
					if (slot_end)
					begin
						if (ack_slot)
						begin
							bit_cnt <= 4'd0;
							if (byte_cnt == 2'd2)
								state <= M_STOP;
							else
								byte_cnt <= byte_cnt + 1'b1;
						end
						else
							bit_cnt <= bit_cnt + 1'b1;
					end
				end
				M_STOP:
				begin
					if (slot_end)
					begin
						state <= M_IDLE;
						done <= 1'b1;
						nack <= nack_acc;
					end
				end
				default: state <= M_IDLE;
			endcase
		end
	end

	// address, register, data, msb first
	always_ff @(posedge clk)
	begin
		if (state == M_IDLE && cmd_valid)
			shift <= {sccb_pkg::SLAVE_ADDR, cmd_reg, cmd_data};
		else if (state == M_BITS && slot_end && !ack_slot)
			shift <= shift << 1;
	end

	// ----------------------------------------
	// pin levels
	// ----------------------------------------
	always_comb
	begin
		scl_d = 1'b1;
		sda_out_d = 1'b1;
		sda_oe_d = 1'b0;
		case (state)
			M_START:
			begin
				if (quarter[1])	// sda falls with scl high
				begin
					sda_oe_d = 1'b1;
					sda_out_d = 1'b0;
				end
			end
			M_BITS:
			begin
				scl_d = quarter[1];
				if (!ack_slot)
				begin
					sda_oe_d = 1'b1;
					sda_out_d = shift[23];
				end
			end
			M_STOP:
			begin
				scl_d = quarter[1];
				sda_oe_d = 1'b1;
				sda_out_d = (quarter == 2'd3);	// rises with scl high
			end
			default: scl_d = 1'b1;
		endcase
		// sda waits one quarter after scl falls
		if ((state == M_BITS || state == M_STOP) && quarter == 2'd0)
		begin
			sda_oe_d = sda_oe;
			sda_out_d = sda_out;
		end
	end

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			scl <= 1'b1;
			sda_out <= 1'b1;
			sda_oe <= 1'b0;
		end
		else
		begin
			scl <= scl_d;
			sda_out <= sda_out_d;
			sda_oe <= sda_oe_d;
		end
	end

endmodule

`default_nettype wire

// File: design/camera_config.sv
`timescale 1ns/100ps
`default_nettype none

module camera_config (
	input wire clk,
	input wire reset_n,
	output logic scl,
	output logic sda_out,
	output logic sda_oe,
	input wire sda_in,
	output logic ready,
	output logic error
);

	logic [sccb_pkg::TABLE_INDEX_W-1:0] index;
	sccb_pkg::sccb_cmd_t cmd;
	logic cmd_valid;
	logic cmd_ready;
	logic [7:0] cmd_reg;
	logic [7:0] cmd_data;
	logic done;
	logic nack;

	// ----------------------------------------
	// table, sequencer, bus engine
	// ----------------------------------------
	init_rom u_rom (
		.index (index),
		.cmd   (cmd)
	);

	init_sequencer u_seq (
		.clk       (clk),
		.reset_n   (reset_n),
		.index     (index),
		.cmd       (cmd),
		.cmd_valid (cmd_valid),
		.cmd_reg   (cmd_reg),
		.cmd_data  (cmd_data),
		.cmd_ready (cmd_ready),
		.done      (done),
		.nack      (nack),
		.ready     (ready),
		.error     (error)
	);

	sccb_master u_sccb (
		.clk       (clk),
		.reset_n   (reset_n),
		.cmd_valid (cmd_valid),
		.cmd_reg   (cmd_reg),
		.cmd_data  (cmd_data),
		.cmd_ready (cmd_ready),
		.done      (done),
		.nack      (nack),
		.scl       (scl),
		.sda_out   (sda_out),
		.sda_oe    (sda_oe),
		.sda_in    (sda_in)	// pad readback
	);

endmodule

`default_nettype wire

// File: tests/sccb_bus_chk.sv
`timescale 1ns/100ps
`default_nettype none

module sccb_bus_chk (
	input wire clk,
	input wire reset_n,
	input wire scl,
	input wire sda_out,
	input wire sda_oe,
	input wire cmd_ready,
	input wire done,
	input wire busy,
	input wire framing,
	input wire ack_high
);

	int violations = 0;
	logic line;

	assign line = sda_oe ? sda_out : 1'b1;	// pull-up when released

	// ----------------------------------------
	// pins lag the master state by one clock
	// ----------------------------------------
	sda_stable: assert property (@(posedge clk) disable iff (!reset_n)
		(scl && $past(scl) && !$past(framing)) |-> (line == $past(line)))
	else
	begin
		violations++;
		$error("sda moved while scl high outside start or stop");
	end

	ack_released: assert property (@(posedge clk) disable iff (!reset_n)
		ack_high |-> !sda_oe)
	else
	begin
		violations++;
		$error("master drives sda during an ack slot");
	end

	// clock low or line pulled down means a transfer is on the wires
	busy_not_ready: assert property (@(posedge clk) disable iff (!reset_n)
		busy |-> !cmd_ready)
	else
	begin
		violations++;
		$error("cmd_ready high during a bus transaction");
	end

	done_after_stop: assert property (@(posedge clk) disable iff (!reset_n)
		done |-> (scl && sda_oe && sda_out))
	else
	begin
		violations++;
		$error("done raised before the stop condition completed");
	end

endmodule

bind sccb_master sccb_bus_chk bus_chk (
	.clk       (clk),
	.reset_n   (reset_n),
	.scl       (scl),
	.sda_out   (sda_out),
	.sda_oe    (sda_oe),
	.cmd_ready (cmd_ready),
	.done      (done),
	.busy      (!scl || (sda_oe && !sda_out)),
	.framing   (state == M_START || state == M_STOP),
	.ack_high  (state == M_BITS && ack_slot && quarter[1])
);

`default_nettype wire

// File: tests/camera_config_tb.sv
`timescale 1ns/100ps
`default_nettype none

module camera_config_tb;

	logic clk;
	logic reset_n;
	logic sda_in;
	logic scl;
	logic sda_out;
	logic sda_oe;
	logic ready;
	logic error;

	logic [15:0] golden [0:12];	// header words, then reg/data pairs
	int run_no;
	int cycle;
	int starts;
	int stops;
	int bit_cnt;
	int data_bits;
	int gap_from;
	logic [23:0] frame;
	logic in_frame;
	logic nack_this;
	logic gap_armed;
	logic scl_q;
	logic sda_q;
	logic ready_q;

	camera_config UUT (
		.clk     (clk),
		.reset_n (reset_n),
		.scl     (scl),
		.sda_out (sda_out),
		.sda_oe  (sda_oe),
		.sda_in  (sda_in),
		.ready   (ready),
		.error   (error)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic report_mismatch(input string msg);
		$display("CHECK FAILED at %0t: %s", $time, msg);
		$display("*** TEST FAILED ***");
		$fatal(1, "stopping at first error");
	endtask

	task automatic report_failure(input string msg);
		$display("ERROR at %0t: %s", $time, msg);
		$display("*** TEST FAILED ***");
		$fatal(1, "stopping at first error");
	endtask

	// run 1 nacks the chosen write once, run 2 on every attempt
	function automatic logic nack_wanted(input int run, input int t);
		if (run == 1)
			return t == int'(golden[1]);
		return t >= int'(golden[1]);
	endfunction

	function automatic int expected_pair(input int run, input int t);
		if (run == 1)
			return (t <= int'(golden[1])) ? t : t - 1;
		return (t < int'(golden[1])) ? t : int'(golden[1]);
	endfunction

	function automatic int expected_total(input int run);
		if (run == 1)
			return int'(golden[0]) + 1;	// one repeat after the nack
		return int'(golden[1]) + sccb_pkg::MAX_RETRIES + 1;
	endfunction

	task automatic check_frame();
		int t;
		int k;
		logic [15:0] want;
		t = stops;
		k = expected_pair(run_no, t);
		assert (t < expected_total(run_no))
		else
			report_mismatch($sformatf("unexpected extra transaction %0d", t));
		// three bytes, then the single clock pulse of the stop
		assert (data_bits == 24 && bit_cnt == 1)
		else
			report_mismatch($sformatf("transaction %0d carried %0d bits, %0d trailing clocks",
				t, data_bits, bit_cnt));
		want = golden[4'(k + 4)];
		assert (frame[23:16] == 8'h60)
		else
			report_mismatch($sformatf("transaction %0d address %h", t, frame[23:16]));
		assert (frame[15:0] == want)
		else
			report_mismatch($sformatf("transaction %0d wrote %h, expected %h", t, frame[15:0], want));
		if (k == int'(golden[2]) && !nack_this)
		begin
			gap_armed = 1'b1;
			gap_from = cycle;
		end
	endtask

	// ----------------------------------------
	// slave model, pins sampled on the falling edge
	// ----------------------------------------
	always @(negedge clk)
	begin
		logic line;
		cycle++;
		line = (sda_oe ? sda_out : 1'b1) & sda_in;
		if (!reset_n)
		begin
			starts = 0;
			stops = 0;
			in_frame = 1'b0;
			gap_armed = 1'b0;
			scl_q = 1'b1;
			sda_q = 1'b1;
			ready_q = 1'b0;
			sda_in <= 1'b1;
		end
		else
		begin
			if (scl && scl_q && sda_q && !line)
			begin
				if (gap_armed)
				begin
					assert (cycle - gap_from >= int'(golden[3]))
					else
						report_mismatch($sformatf("only %0d clocks after soft reset", cycle - gap_from));
					gap_armed = 1'b0;
				end
				assert (!in_frame) else report_mismatch("start inside an open transaction");
				in_frame = 1'b1;
				bit_cnt = 0;
				data_bits = 0;
				nack_this = nack_wanted(run_no, starts);
				starts++;
			end
			else if (in_frame && scl && scl_q && !sda_q && line)
			begin
				check_frame();
				stops++;
				in_frame = 1'b0;
			end
			else if (in_frame && scl && !scl_q)
			begin
				if (bit_cnt < 8 && data_bits < 24)	// stop clock carries no data
				begin
					frame = {frame[22:0], line};
					data_bits++;
				end
				bit_cnt++;
			end
			else if (in_frame && !scl && scl_q)
			begin
				if (bit_cnt == 8)
					sda_in <= nack_this;	// low acknowledges
				else if (bit_cnt == 9)
				begin
					sda_in <= 1'b1;
					bit_cnt = 0;
				end
			end
			if (ready && !ready_q)
				assert (run_no == 1 && stops == expected_total(run_no))
				else
					report_mismatch($sformatf("ready rose after %0d transactions", stops));
			if (run_no == 1)
				assert (!error) else report_mismatch("error raised during the normal run");
			assert (!(ready && error)) else report_mismatch("ready and error high together");
			assert (UUT.u_sccb.bus_chk.violations == 0)
			else
				report_failure("a bus protocol assertion fired");
			scl_q = scl;
			sda_q = line;
			ready_q = ready;
		end
	end

	task automatic apply_reset();
		@(negedge clk);
		reset_n = 1'b0;
		repeat (4) @(negedge clk);
		reset_n = 1'b1;
	endtask

	task automatic wait_for_flag(input logic want_error, input int limit, input string what);
		int n;
		n = 0;
		while ((want_error ? !error : !ready) && n < limit)
		begin
			@(negedge clk);
			n++;
		end
		if (want_error ? !error : !ready)
			report_failure($sformatf("timed out after %0d clocks waiting for %s", limit, what));
	endtask

	// bounded window, the bus must stay silent
	task automatic watch_idle(input int limit);
		int n;
		int first;
		first = starts;
		for (n = 0; n < limit; n++)
		begin
			@(negedge clk);
			assert (starts == first) else report_mismatch("start condition after the engine stopped");
			if (run_no == 2)
				assert (!ready && scl && !sda_oe)
				else
					report_mismatch("bus not idle after error");
		end
	endtask

	initial
	begin
		reset_n = 1'b0;
		sda_in = 1'b1;
		cycle = 0;
		run_no = 1;
		$readmemh("tests/camera_golden.txt", golden);
		apply_reset();
		wait_for_flag(1'b0, 20000, "ready");
		assert (stops == expected_total(1))
		else
			report_mismatch($sformatf("%0d transactions before ready", stops));
		watch_idle(2000);

		// second run, the chosen write never acknowledged
		run_no = 2;
		$readmemh("tests/camera_golden.txt", golden);
		apply_reset();
		wait_for_flag(1'b1, 20000, "error");
		assert (stops == expected_total(2))
		else
			report_mismatch($sformatf("%0d transactions before error", stops));
		watch_idle(2000);
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/camera_golden.txt
// one 16-bit hex word per line
// word 0 pair count, 1 nacked pair, 2 soft reset pair, 3 minimum gap in clocks
0009
0004
0001
0140
// then register byte and data byte of each write, in bus order
ff01
1280
ff00
2cff
2edf
ff01
3c32
1100
0902

// File: camera_config.f
design/sccb_pkg.sv
design/init_rom.sv
design/init_sequencer.sv
design/sccb_master.sv
design/camera_config.sv
tests/sccb_bus_chk.sv
tests/camera_config_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = camera_config_tb
FILELIST  = camera_config.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = *** TEST FAILED ***

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# a crashed or aborted run also counts as a failure
sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	cat $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
